// ==== design/amiga_scan_doubler.sv ====
`timescale 1ns/1ps
// --------------------
// Line doubler from a 30-bit digitizer to a 24-bit display port
// Everything runs on in_hs, the doubled display clock
// --------------------

module amiga_scan_doubler
	import scan_pkg::*;
(
	// Clock and reset
	input  logic       in_hs,
	input  logic       rst,
	// Digitizer side
	input  logic       src_hsync,
	input  logic       src_vsync,
	input  logic       src_pixel_en,
	input  cap_pixel_t src_data,
	// Display side
	output logic       out_pclk,
	output logic       out_hsync,
	output logic       out_vsync,
	output rgb888_t    out_rgb,
	// External SRAM
	output fb_addr_t   sram_addr,
	inout  wire [15:0] sram_data,
	output logic       sram_we_n,
	output logic       sram_oe_n
);

	// Slot traffic between capture, display and the bus owner
	sram_slot_if slot ();

	// --------------------
	// Capture
	// --------------------
	frame_writer u_writer (
		.in_hs        (in_hs),
		.rst          (rst),
		.src_hsync    (src_hsync),
		.src_vsync    (src_vsync),
		.src_pixel_en (src_pixel_en),
		.src_data     (src_data),
		.slot         (slot.writer)
	);

	// --------------------
	// SRAM bus
	// --------------------
	sram_sequencer u_sequencer (
		.in_hs     (in_hs),
		.rst       (rst),
		.slot      (slot.sequencer),
		.sram_addr (sram_addr),
		.sram_data (sram_data),
		.sram_we_n (sram_we_n),
		.sram_oe_n (sram_oe_n)
	);

	// --------------------
	// Display
	// --------------------
	display_raster u_raster (
		.in_hs     (in_hs),
		.rst       (rst),
		.slot      (slot.raster),
		.out_pclk  (out_pclk),
		.out_hsync (out_hsync),
		.out_vsync (out_vsync),
		.out_rgb   (out_rgb)
	);

endmodule

// ==== design/display_raster.sv ====
`timescale 1ns/1ps
// --------------------
// Two display pixels per slot, each stored pixel shown on both of them
// Syncs and colour reach the pins one display pixel after their counter value
// --------------------
`include "scan_settings.svh"

module display_raster
	import scan_pkg::*;
(
	input  logic        in_hs,
	input  logic        rst,
	sram_slot_if.raster slot,
	output logic        out_pclk,
	output logic        out_hsync,
	output logic        out_vsync,
	output rgb888_t     out_rgb
);

	// --------------------
	// Raster geometry
	// --------------------
	localparam int H_BLANK    = `DISP_HFP + `DISP_HSW + `DISP_HBP;
	localparam int V_BLANK    = `DISP_VFP + `DISP_VSW + `DISP_VBP;
	localparam int H_TOTAL    = H_BLANK + `DISP_WIDTH;
	localparam int V_TOTAL    = V_BLANK + `DISP_HEIGHT;
	// Picture window, doubled in both directions
	localparam int PIC_LEFT   = H_BLANK;
	localparam int PIC_RIGHT  = H_BLANK + 2 * `FB_WIDTH;
	localparam int PIC_TOP    = V_BLANK + `DISP_V_OFFSET;
	localparam int PIC_BOTTOM = PIC_TOP + 2 * `FB_HEIGHT;
	localparam int H_W        = $clog2(H_TOTAL + 1);
	localparam int V_W        = $clog2(V_TOTAL + 1);

	logic [H_W-1:0] h_cnt;
	logic [H_W-1:0] h_ahead;
	logic [V_W-1:0] v_cnt;
	logic [V_W-1:0] pic_row;
	logic           advance;
	logic           line_end;
	logic           frame_end;
	logic           pic_line;
	logic           show_pic;
	logic           fetch_pic;
	fb_addr_t       rd_ptr;

	// Stored colour widened with zero low bits
	function automatic rgb888_t expand565(input rgb565_t px);
		rgb888_t wide;
		wide.red   = {px.red, 3'b000};
		wide.green = {px.green, 2'b00};
		wide.blue  = {px.blue, 3'b000};
		return wide;
	endfunction

	// --------------------
	// Counters
	// --------------------
	// One display pixel after PH_LAUNCH and one after PH_WRITE_DATA
	assign advance   = (slot.phase == PH_LAUNCH) || (slot.phase == PH_WRITE_DATA);
	assign line_end  = advance && (h_cnt == H_TOTAL - 1);
	assign frame_end = line_end && (v_cnt == V_TOTAL - 1);

	// Starting on the last pixel makes the first advance open a clean frame
	always_ff @(posedge in_hs) begin
		if (rst) begin
			h_cnt <= H_W'(H_TOTAL - 1);
			v_cnt <= V_W'(V_TOTAL - 1);
		end else if (advance) begin
			if (line_end) begin
				h_cnt <= '0;
				v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// --------------------
	// Picture window
	// --------------------
	always_comb begin
		pic_line = (v_cnt >= PIC_TOP) && (v_cnt < PIC_BOTTOM);
		pic_row  = v_cnt - V_W'(PIC_TOP);
		// In PH_CAPTURE the count is the first pixel of the pair being shown
		show_pic = pic_line && (h_cnt >= PIC_LEFT) && (h_cnt < PIC_RIGHT);
		// In PH_READ_ADDR the next PH_CAPTURE will hold one count further
		h_ahead   = h_cnt + 1'b1;
		fetch_pic = pic_line && (h_ahead >= PIC_LEFT) && (h_ahead < PIC_RIGHT);
	end

	// --------------------
	// Read addressing
	// --------------------
	assign slot.rd_en   = (slot.phase == PH_READ_ADDR) && fetch_pic;
	assign slot.rd_addr = rd_ptr;

	// First line of a pair rewinds so the second line reads the same words
	always_ff @(posedge in_hs) begin
		if (rst) begin
			rd_ptr <= '0;
		end else if (frame_end) begin
			rd_ptr <= '0;
		end else if (line_end && pic_line && !pic_row[0]) begin
			rd_ptr <= rd_ptr - fb_addr_t'(`FB_WIDTH);
		end else if (slot.rd_en) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// --------------------
	// Outputs
	// --------------------
	always_ff @(posedge in_hs) begin
		if (rst) begin
			out_pclk  <= 1'b0;
			out_hsync <= 1'b0;
			out_vsync <= 1'b0;
			out_rgb   <= '0;
		end else begin
			out_pclk  <= advance;
			out_hsync <= (h_cnt >= `DISP_HFP) && (h_cnt < `DISP_HFP + `DISP_HSW);
			out_vsync <= (v_cnt >= `DISP_VFP) && (v_cnt < `DISP_VFP + `DISP_VSW);
			// New colour lands between the two clock pulses of its pixel pair
			if (slot.phase == PH_CAPTURE) begin
				out_rgb <= show_pic ? expand565(slot.rd_data) : '0;
			end
		end
	end

endmodule

// ==== design/frame_writer.sv ====
`timescale 1ns/1ps
// --------------------
// Source pixels must come at least four clocks apart
// There is no stall toward the source, a newer pixel replaces a waiting one
// Capture counters are 12 bits wide and wrap on longer lines or frames
// --------------------
`include "scan_settings.svh"

module frame_writer
	import scan_pkg::*;
(
	input  logic        in_hs,
	input  logic        rst,
	input  logic        src_hsync,
	input  logic        src_vsync,
	input  logic        src_pixel_en,
	input  cap_pixel_t  src_data,
	sram_slot_if.writer slot
);

	localparam int CNT_W = 12;
	// Capture window edges in source pixels and source lines
	localparam int X_LO  = `CAP_HBLANK;
	localparam int X_HI  = `CAP_HBLANK + `FB_WIDTH;
	localparam int Y_LO  = `CAP_VBLANK;
	localparam int Y_HI  = `CAP_VBLANK + `FB_HEIGHT;

	logic [CNT_W-1:0] pix_cnt;
	logic [CNT_W-1:0] line_cnt;
	logic             hsync_d;
	logic             in_window;
	logic             hit;
	logic [CNT_W-1:0] x_off;
	logic [CNT_W-1:0] y_off;
	logic [CNT_W-1:0] lin_addr;

	// Keep the top bits of each 10-bit channel
	function automatic rgb565_t pack565(input cap_pixel_t px);
		rgb565_t word;
		word.red   = px.red[9:5];
		word.green = px.green[9:4];
		word.blue  = px.blue[9:5];
		return word;
	endfunction

	// --------------------
	// Position counters
	// --------------------
	// Pixel index within the line, held at zero through horizontal sync low
	always_ff @(posedge in_hs) begin
		if (rst) begin
			pix_cnt <= '0;
		end else if (!src_hsync) begin
			pix_cnt <= '0;
		end else if (src_pixel_en) begin
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

	// Line index within the frame, bumped on every rising source hsync
	always_ff @(posedge in_hs) begin
		if (rst) begin
			hsync_d  <= 1'b0;
			line_cnt <= '0;
		end else begin
			hsync_d <= src_hsync;
			if (!src_vsync) begin
				line_cnt <= '0;
			end else if (src_hsync && !hsync_d) begin
				line_cnt <= line_cnt + 1'b1;
			end
		end
	end

	// --------------------
	// Window test and address
	// --------------------
	always_comb begin
		in_window = (pix_cnt >= X_LO) && (pix_cnt < X_HI)
			&& (line_cnt >= Y_LO) && (line_cnt < Y_HI);
		// Offsets are only meaningful inside the window
		x_off    = pix_cnt - CNT_W'(X_LO);
		y_off    = line_cnt - CNT_W'(Y_LO);
		lin_addr = x_off + y_off * CNT_W'(`FB_WIDTH);
	end

	// The counters still hold this pixel's index in the cycle it is marked
	assign hit = src_pixel_en && src_hsync && in_window;

	// --------------------
	// Pending write
	// --------------------
	// A fresh pixel wins over the acceptance of the previous one
	always_ff @(posedge in_hs) begin
		if (rst) begin
			slot.wr_pending <= 1'b0;
		end else if (hit) begin
			slot.wr_pending <= 1'b1;
		end else if (slot.wr_taken) begin
			slot.wr_pending <= 1'b0;
		end
	end

	// Address and data of the waiting pixel
	always_ff @(posedge in_hs) begin
		if (hit) begin
			slot.wr_addr <= fb_addr_t'(lin_addr);
			slot.wr_data <= pack565(src_data);
		end
	end

endmodule

// ==== design/scan_pkg.sv ====
// --------------------
// Types shared by the capture, sequencer and display blocks
// Address width follows the frame buffer size in the settings header
// --------------------
`include "scan_settings.svh"

package scan_pkg;

	// --------------------
	// Frame buffer addressing
	// --------------------
	// One word per stored pixel, so the address covers width times height
	localparam int FB_ADDR_W = $clog2(`FB_WIDTH * `FB_HEIGHT);

	typedef logic [FB_ADDR_W-1:0] fb_addr_t;

	// --------------------
	// Pixel formats
	// --------------------
	// Stored pixel as it sits in one 16-bit SRAM word
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// Pixel as it leaves toward the HDMI transmitter
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb888_t;

	// Raw digitizer sample, red in the top ten bits
	typedef struct packed {
		logic [9:0] red;
		logic [9:0] green;
		logic [9:0] blue;
	} cap_pixel_t;

	// Four clocks of one SRAM slot, in the order they run
	typedef enum logic [1:0] {PH_LAUNCH, PH_CAPTURE, PH_WRITE_DATA, PH_READ_ADDR} slot_phase_t;

endpackage

// ==== design/sram_sequencer.sv ====
`timescale 1ns/1ps
// --------------------
// Asynchronous 16-bit SRAM with chip and byte enables tied active outside
// One write and one read share every four-clock slot
// --------------------

module sram_sequencer
	import scan_pkg::*;
(
	input  logic           in_hs,
	input  logic           rst,
	sram_slot_if.sequencer slot,
	output fb_addr_t       sram_addr,
	inout  wire [15:0]     sram_data,
	output logic           sram_we_n,
	output logic           sram_oe_n
);

	slot_phase_t phase;
	// Pixel word held on the bus during PH_WRITE_DATA
	rgb565_t     wr_word;
	// A waiting pixel is claimed in PH_CAPTURE
	logic        take_write;

	// --------------------
	// Slot phase
	// --------------------
	// Free running from reset, the display relies on the fixed order
	always_ff @(posedge in_hs) begin
		if (rst) begin
			phase <= PH_LAUNCH;
		end else begin
			case (phase)
				PH_LAUNCH:     phase <= PH_CAPTURE;
				PH_CAPTURE:    phase <= PH_WRITE_DATA;
				PH_WRITE_DATA: phase <= PH_READ_ADDR;
				default:       phase <= PH_LAUNCH;
			endcase
		end
	end

	assign slot.phase = phase;

	// --------------------
	// Write acceptance
	// --------------------
	// The writer drops its request on this pulse unless a newer pixel arrives
	assign take_write    = (phase == PH_CAPTURE) && slot.wr_pending;
	assign slot.wr_taken = take_write;

	always_ff @(posedge in_hs) begin
		if (take_write) begin
			wr_word <= slot.wr_data;
		end
	end

	// --------------------
	// SRAM pins
	// --------------------
	// Write strobe is low for the single PH_WRITE_DATA cycle of a taken write
	// Output enable goes high in that same cycle so the SRAM lets go of the bus
	always_ff @(posedge in_hs) begin
		if (rst) begin
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b0;
			sram_addr <= '0;
		end else begin
			sram_we_n <= !take_write;
			sram_oe_n <= take_write;
			case (phase)
				// Write address sits on the bus through PH_WRITE_DATA
				PH_CAPTURE: begin
					if (take_write) begin
						sram_addr <= slot.wr_addr;
					end
				end
				// Read address holds through PH_LAUNCH and PH_CAPTURE
				PH_READ_ADDR: begin
					sram_addr <= slot.rd_en ? slot.rd_addr : '0;
				end
				default: begin
					sram_addr <= sram_addr;
				end
			endcase
		end
	end

	// The FPGA drives data only while the write strobe is low
	assign sram_data = sram_we_n ? 16'bz : wr_word;

	// SRAM answer to the read address, registered by the raster in PH_CAPTURE
	assign slot.rd_data = rgb565_t'(sram_data);

endmodule

// ==== design/sram_slot_if.sv ====
`timescale 1ns/1ps
// --------------------
// Shares one SRAM slot between a capture write and a display read
// The read data is only meaningful during PH_CAPTURE
// --------------------

interface sram_slot_if
	import scan_pkg::*;
();

	// --------------------
	// Write group
	// --------------------
	// High while a captured pixel waits for its slot
	logic        wr_pending;
	fb_addr_t    wr_addr;
	rgb565_t     wr_data;
	// Pulses in the cycle the sequencer accepts the pending pixel
	logic        wr_taken;

	// --------------------
	// Read group
	// --------------------
	// Presented by the raster during PH_READ_ADDR
	fb_addr_t    rd_addr;
	logic        rd_en;
	// Word on the SRAM bus, sampled by the raster in PH_CAPTURE
	rgb565_t     rd_data;
	// Current slot phase, owned by the sequencer
	slot_phase_t phase;

	// Capture side
	modport writer (output wr_pending, wr_addr, wr_data, input wr_taken);

	// Display side
	modport raster (output rd_addr, rd_en, input rd_data, phase);

	// SRAM bus owner
	modport sequencer (
		input  wr_pending, wr_addr, wr_data, rd_addr, rd_en,
		output wr_taken, rd_data, phase
	);

endinterface

// ==== filelist.f ====
+incdir+include
design/scan_pkg.sv
design/sram_slot_if.sv
design/frame_writer.sv
design/sram_sequencer.sv
design/display_raster.sv
design/amiga_scan_doubler.sv
verification/tb_clock.sv
verification/scan_properties.sv
verification/tb_top.sv

// ==== include/scan_settings.svh ====
// --------------------
// Small geometry for simulation with an 8x4 frame buffer
// Scale these values up for real 720p output timing
// Horizontal blanking and DISP_WIDTH must both be even
// --------------------
`ifndef SCAN_SETTINGS_SVH
`define SCAN_SETTINGS_SVH

// --------------------
// Capture window
// --------------------
// Source pixels skipped after the source hsync rises
`define CAP_HBLANK 4
// Source lines skipped after the source vsync rises
`define CAP_VBLANK 2

// --------------------
// Frame buffer
// --------------------
// Stored pixels per line and stored lines per frame
`define FB_WIDTH 8
`define FB_HEIGHT 4

// --------------------
// Display timing
// --------------------
// Horizontal front porch, sync width and back porch in display pixels
`define DISP_HFP 4
`define DISP_HSW 2
`define DISP_HBP 2
// Vertical front porch, sync width and back porch in display lines
`define DISP_VFP 1
`define DISP_VSW 1
`define DISP_VBP 1
// Active area, which must hold twice the frame buffer in both directions
`define DISP_WIDTH 20
`define DISP_HEIGHT 10
// Lines from the top of the active area down to the first picture line
`define DISP_V_OFFSET 1

`endif

// ==== verification/scan_properties.sv ====
`timescale 1ns/1ps
// --------------------
// Bound once to the sequencer and once to the raster
// Inputs that a binding does not use are tied to their idle level
// --------------------
`include "scan_settings.svh"

module scan_properties (
	input logic in_hs,
	input logic rst,
	input logic we_n,
	input logic hsync
);

	// Failed properties of this instance, added to the testbench totals
	int fail_count = 0;

	// A write strobe covers a single PH_WRITE_DATA clock
	assert property (@(posedge in_hs) disable iff (rst) !we_n |=> we_n)
		else begin
			fail_count++;
			$error("SRAM write strobe stayed low for two clocks");
		end

	// Each display pixel lasts two clocks, so the pulse is twice the sync width
	assert property (@(posedge in_hs) disable iff (rst)
		$rose(hsync) |-> hsync [* (2 * `DISP_HSW)] ##1 !hsync)
		else begin
			fail_count++;
			$error("Display hsync pulse has the wrong width");
		end

endmodule

// SRAM strobe check on the bus owner
bind sram_sequencer scan_properties u_bus_props (
	.in_hs (in_hs),
	.rst   (rst),
	.we_n  (sram_we_n),
	.hsync (1'b0)
);

// Sync width check on the raster
bind display_raster scan_properties u_sync_props (
	.in_hs (in_hs),
	.rst   (rst),
	.we_n  (1'b1),
	.hsync (out_hsync)
);

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps
// --------------------
// Free-running clock for the whole testbench
// Reset is released on a falling edge after the last reset cycle
// --------------------

module tb_clock #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic in_hs,
	output logic rst
);

	// Square wave with an even split of the period
	initial begin
		in_hs = 1'b0;
		forever #(PERIOD_NS / 2) in_hs = ~in_hs;
	end

	// Reset covers the first rising edges and drops between two of them
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge in_hs);
		@(negedge in_hs);
		rst = 1'b0;
	end

endmodule

// ==== verification/tb_top.sv ====
`timescale 1ns/1ps
// --------------------
// Captures one random frame, then checks two full display frames
// The SRAM model writes in the middle of a low write strobe
// --------------------
`include "scan_settings.svh"

module tb_top
	import scan_pkg::*;
();

	localparam int FB_WORDS    = `FB_WIDTH * `FB_HEIGHT;
	localparam int PIC_LEFT    = `DISP_HFP + `DISP_HSW + `DISP_HBP;
	localparam int PIC_TOP     = `DISP_VFP + `DISP_VSW + `DISP_VBP + `DISP_V_OFFSET;
	localparam int H_TOTAL     = PIC_LEFT + `DISP_WIDTH;
	localparam int V_TOTAL     = `DISP_VFP + `DISP_VSW + `DISP_VBP + `DISP_HEIGHT;
	// Capture covers the window plus some pixels and lines outside it
	localparam int CAP_LINES   = `CAP_VBLANK + `FB_HEIGHT + 1;
	localparam int CAP_PIXELS  = `CAP_HBLANK + `FB_WIDTH + 2;
	localparam int LAT_MIN     = 2;
	localparam int LAT_MAX     = 5;
	localparam int FRAME_LIMIT = 4 * 2 * H_TOTAL * V_TOTAL;

	logic        in_hs;
	logic        rst;
	logic        src_hsync;
	logic        src_vsync;
	logic        src_pixel_en;
	logic [29:0] src_data;
	logic        out_pclk;
	logic        out_hsync;
	logic        out_vsync;
	rgb888_t     out_rgb;
	fb_addr_t    sram_addr;
	wire  [15:0] sram_data;
	logic        sram_we_n;
	logic        sram_oe_n;

	// --------------------
	// Model state
	// --------------------
	logic [15:0] sram_mem [FB_WORDS];
	logic [15:0] exp_fb [FB_WORDS];
	// Expected writes in source order with the cycle of their pixel
	int          exp_wr_addr[$];
	logic [15:0] exp_wr_data[$];
	int          exp_wr_cycle[$];
	logic [31:0] rng_state = 32'd82425;
	int          cycle_count = 0;
	// Position of the display pixel carried by the next out_pclk pulse
	int          disp_h = H_TOTAL - 1;
	int          disp_v = V_TOTAL - 1;
	logic        fb_stable = 1'b0;
	logic        frame_checked = 1'b0;
	int          frames_done = 0;
	int          write_errors = 0;
	int          sync_errors = 0;
	int          pixel_errors = 0;
	int          flow_errors = 0;

	tb_clock u_clock (.in_hs(in_hs), .rst(rst));

	amiga_scan_doubler DUT (
		.in_hs        (in_hs),
		.rst          (rst),
		.src_hsync    (src_hsync),
		.src_vsync    (src_vsync),
		.src_pixel_en (src_pixel_en),
		.src_data     (src_data),
		.out_pclk     (out_pclk),
		.out_hsync    (out_hsync),
		.out_vsync    (out_vsync),
		.out_rgb      (out_rgb),
		.sram_addr    (sram_addr),
		.sram_data    (sram_data),
		.sram_we_n    (sram_we_n),
		.sram_oe_n    (sram_oe_n)
	);

	// --------------------
	// Helpers
	// --------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Power-up content of the SRAM that differs for every address bit
	function automatic logic [15:0] fill_word(input int addr);
		return 16'((addr * 40503) ^ (addr << 11) ^ 16'h3C5A);
	endfunction

	// Top 5, 6 and 5 bits of the red, green and blue channels
	function automatic logic [15:0] pack_rgb565(input logic [29:0] d);
		return {d[29:25], d[19:14], d[9:5]};
	endfunction

	function automatic logic [23:0] expand_rgb565(input logic [15:0] w);
		return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
	endfunction

	function automatic logic in_capture_window(input int line, input int pix);
		return (pix >= `CAP_HBLANK) && (pix < `CAP_HBLANK + `FB_WIDTH)
			&& (line >= `CAP_VBLANK) && (line < `CAP_VBLANK + `FB_HEIGHT);
	endfunction

	task automatic report_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[FAIL] time %0t %s expected %0h got %0h", $time, name, expected, actual);
	endtask

	// --------------------
	// SRAM model
	// --------------------
	assign sram_data = (sram_we_n === 1'b1) ? sram_mem[sram_addr] : 16'bz;

	always @(negedge in_hs) begin
		if (sram_we_n === 1'b0) begin
			sram_mem[sram_addr] <= sram_data;
		end
	end

	always @(posedge in_hs) begin
		cycle_count <= cycle_count + 1;
	end

	// --------------------
	// Write checker
	// --------------------
	// Writes must arrive in pixel order and each within the latency bound
	always @(negedge in_hs) begin
		if (sram_we_n === 1'b0) begin
			assert (exp_wr_addr.size() != 0) else begin
				$display("Unexpected SRAM write to address %0d at time %0t", sram_addr, $time);
				write_errors++;
			end
			if (exp_wr_addr.size() != 0) begin
				assert (int'(sram_addr) == exp_wr_addr[0]) else begin
					report_value("sram_addr", exp_wr_addr[0], sram_addr);
					write_errors++;
				end
				assert (sram_data === exp_wr_data[0]) else begin
					report_value("sram_data", exp_wr_data[0], sram_data);
					write_errors++;
				end
				assert (cycle_count - exp_wr_cycle[0] >= LAT_MIN) else begin
					$display("SRAM write came too soon after its pixel at time %0t", $time);
					write_errors++;
				end
				void'(exp_wr_addr.pop_front());
				void'(exp_wr_data.pop_front());
				void'(exp_wr_cycle.pop_front());
			end
		end else if (exp_wr_addr.size() != 0) begin
			assert (cycle_count - exp_wr_cycle[0] <= LAT_MAX) else begin
				$display("No SRAM write for address %0d within %0d cycles", exp_wr_addr[0],
					LAT_MAX);
				write_errors++;
				void'(exp_wr_addr.pop_front());
				void'(exp_wr_data.pop_front());
				void'(exp_wr_cycle.pop_front());
			end
		end
	end

	// --------------------
	// Display checker
	// --------------------
	// Each pulse carries the counter position that was current before it
	always @(negedge in_hs) begin : pulse_check
		logic        exp_hs;
		logic        exp_vs;
		logic        in_pic;
		int          addr;
		logic [23:0] exp_rgb;
		if (out_pclk === 1'b1) begin
			exp_hs = (disp_h >= `DISP_HFP) && (disp_h < `DISP_HFP + `DISP_HSW);
			exp_vs = (disp_v >= `DISP_VFP) && (disp_v < `DISP_VFP + `DISP_VSW);
			in_pic = (disp_v >= PIC_TOP) && (disp_v < PIC_TOP + 2 * `FB_HEIGHT)
				&& (disp_h >= PIC_LEFT) && (disp_h < PIC_LEFT + 2 * `FB_WIDTH);
			// Content is compared only in frames that start after the capture settled
			if (disp_h == 0 && disp_v == 0) begin
				if (frame_checked) begin
					frames_done++;
				end
				frame_checked = fb_stable;
			end
			assert (out_hsync === exp_hs) else begin
				report_value("out_hsync", exp_hs, out_hsync);
				sync_errors++;
			end
			assert (out_vsync === exp_vs) else begin
				report_value("out_vsync", exp_vs, out_vsync);
				sync_errors++;
			end
			if (!in_pic) begin
				assert (out_rgb === 24'h0) else begin
					report_value("out_rgb", 24'h0, out_rgb);
					pixel_errors++;
				end
			end else if (frame_checked) begin
				// Two display pixels and two display lines per stored pixel
				addr = ((disp_v - PIC_TOP) / 2) * `FB_WIDTH + (disp_h - PIC_LEFT) / 2;
				exp_rgb = expand_rgb565(exp_fb[addr]);
				assert (out_rgb === exp_rgb) else begin
					report_value("out_rgb", exp_rgb, out_rgb);
					pixel_errors++;
				end
			end
			if (disp_h == H_TOTAL - 1) begin
				disp_h = 0;
				disp_v = (disp_v == V_TOTAL - 1) ? 0 : disp_v + 1;
			end else begin
				disp_h = disp_h + 1;
			end
		end
	end

	// --------------------
	// Stimulus
	// --------------------
	// One pixel strobe followed by a random gap of four to seven clocks
	task automatic send_pixel(input int line, input int pix);
		logic [31:0] r0;
		logic [31:0] r1;
		logic [29:0] data;
		int          gap;
		int          addr;
		rng_state = lcg_next(rng_state);
		r0 = rng_state;
		rng_state = lcg_next(rng_state);
		r1 = rng_state;
		data = {r0[30:16], r1[30:16]};
		gap = 4 + int'(r1[13:12]);
		@(negedge in_hs);
		src_pixel_en = 1'b1;
		src_data = data;
		if (in_capture_window(line, pix)) begin
			addr = (pix - `CAP_HBLANK) + (line - `CAP_VBLANK) * `FB_WIDTH;
			exp_wr_addr.push_back(addr);
			exp_wr_data.push_back(pack_rgb565(data));
			exp_wr_cycle.push_back(cycle_count);
			exp_fb[addr] = pack_rgb565(data);
		end
		@(negedge in_hs);
		src_pixel_en = 1'b0;
		repeat (gap - 2) @(negedge in_hs);
	endtask

	// Line numbers start at one with the first hsync rise after vsync goes high
	task automatic send_frame();
		int line;
		int pix;
		@(negedge in_hs);
		src_vsync = 1'b0;
		src_hsync = 1'b0;
		repeat (4) @(negedge in_hs);
		src_vsync = 1'b1;
		for (line = 1; line <= CAP_LINES; line++) begin
			repeat (3) @(negedge in_hs);
			src_hsync = 1'b1;
			repeat (2) @(negedge in_hs);
			for (pix = 0; pix < CAP_PIXELS; pix++) begin
				send_pixel(line, pix);
			end
			@(negedge in_hs);
			src_hsync = 1'b0;
		end
		repeat (3) @(negedge in_hs);
		src_vsync = 1'b0;
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		int i;
		int waited;
		int property_errors;
		src_hsync    = 1'b0;
		src_vsync    = 1'b0;
		src_pixel_en = 1'b0;
		src_data     = '0;
		for (i = 0; i < FB_WORDS; i++) begin
			sram_mem[i] = fill_word(i);
			exp_fb[i]   = fill_word(i);
		end

		// Output levels while reset is held
		repeat (2) @(posedge in_hs);
		@(negedge in_hs);
		assert (out_pclk === 1'b0) else begin
			report_value("out_pclk", 0, out_pclk);
			flow_errors++;
		end
		assert (out_hsync === 1'b0 && out_vsync === 1'b0) else begin
			report_value("out_hsync/out_vsync", 0, {out_hsync, out_vsync});
			flow_errors++;
		end
		assert (sram_we_n === 1'b1 && sram_oe_n === 1'b0) else begin
			report_value("sram_we_n/sram_oe_n", 2'b10, {sram_we_n, sram_oe_n});
			flow_errors++;
		end
		assert (out_rgb === 24'h0) else begin
			report_value("out_rgb", 0, out_rgb);
			flow_errors++;
		end

		waited = 0;
		while (rst !== 1'b0 && waited < 20) begin
			@(posedge in_hs);
			waited++;
		end
		assert (rst === 1'b0) else begin
			$display("Reset was never released");
			flow_errors++;
		end

		send_frame();

		waited = 0;
		while (exp_wr_addr.size() != 0 && waited < 4 * LAT_MAX) begin
			@(negedge in_hs);
			waited++;
		end
		assert (exp_wr_addr.size() == 0) else begin
			$display("Timeout while waiting for the last SRAM writes");
			flow_errors++;
		end
		@(negedge in_hs);
		for (i = 0; i < FB_WORDS; i++) begin
			assert (sram_mem[i] === exp_fb[i]) else begin
				report_value($sformatf("sram_mem[%0d]", i), exp_fb[i], sram_mem[i]);
				write_errors++;
			end
		end
		fb_stable = 1'b1;

		waited = 0;
		while (frames_done < 2 && waited < FRAME_LIMIT) begin
			@(negedge in_hs);
			waited++;
		end
		assert (frames_done >= 2) else begin
			$display("Timeout while waiting for two checked display frames");
			flow_errors++;
		end

		// Failed concurrent properties of both bound checkers
		property_errors = DUT.u_sequencer.u_bus_props.fail_count
			+ DUT.u_raster.u_sync_props.fail_count;

		$display("Error counts: write %0d, sync %0d, pixel %0d, flow %0d, property %0d",
			write_errors, sync_errors, pixel_errors, flow_errors, property_errors);
		if (write_errors + sync_errors + pixel_errors + flow_errors
			+ property_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
